// File: verilog/issue_pkg.sv
package issue_pkg;

    // Data path and register index widths
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;

    // Integer register file depth
    localparam int NUM_REGS  = 32;

    // Instructions, operands and results
    typedef logic [WORD_W-1:0]    word_t;

    // Architectural register number
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Field positions in the instruction word
    // rs1 sits at [19:15], rs2 at [24:20], rd at [11:7]
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int RD_LSB  = 7;

    // x0 reads as zero and drops writes
    localparam reg_idx_t REG_ZERO = '0;

endpackage

// File: verilog/issue_select.sv
`timescale 1ns/1ps

module issue_select
    import issue_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    // Fetch side
    input  logic     fetch_valid_i,
    input  word_t    fetch_instr_i,
    input  logic     fetch_rd_valid_i,
    input  logic     fetch_load_i,
    input  logic     fetch_mul_i,

    // Producer in E1 and pipe stall
    input  logic     e1_busy_i,
    input  reg_idx_t e1_rd_i,
    input  logic     stall_i,

    output logic     issue_o,
    output logic     fetch_accept_o,
    output logic     opcode_valid_o,
    output reg_idx_t ra_idx_o,
    output reg_idx_t rb_idx_o,
    output reg_idx_t rd_idx_o
);

    reg_idx_t              ra_idx_w;
    reg_idx_t              rb_idx_w;
    reg_idx_t              rd_idx_w;
    logic [NUM_REGS-1:0]   scoreboard_w;
    logic                  hazard_w;
    logic                  issue_w;

    // Register fields of the fetched word
    assign ra_idx_w = fetch_instr_i[RS1_LSB +: REG_IDX_W];
    assign rb_idx_w = fetch_instr_i[RS2_LSB +: REG_IDX_W];
    assign rd_idx_w = fetch_instr_i[RD_LSB +: REG_IDX_W];

    // Loads and multiplies have no result until E2, so their
    // destination is busy for the one cycle they spend in E1
    always_comb
    begin
        scoreboard_w = '0;
        if (e1_busy_i)
            scoreboard_w[e1_rd_i] = 1'b1;
    end

    // rd is checked too so writeback keeps program order
    assign hazard_w = scoreboard_w[ra_idx_w]
                    | scoreboard_w[rb_idx_w]
                    | scoreboard_w[rd_idx_w];

    // Issue decision
    assign issue_w = fetch_valid_i && !stall_i && !hazard_w;

    assign issue_o        = issue_w;
    assign opcode_valid_o = issue_w;

    // Idle fetch is always accepted
    assign fetch_accept_o = fetch_valid_i ? issue_w : 1'b1;

    assign ra_idx_o = ra_idx_w;
    assign rb_idx_o = rb_idx_w;
    assign rd_idx_o = rd_idx_w;

    // Fetch keeps a refused instruction steady until it goes in
    a_fetch_hold : assert property (
        @(posedge clk_i) disable iff (rst_i)
        fetch_valid_i && !fetch_accept_o
            |=> fetch_valid_i
                && $stable(fetch_instr_i)
                && $stable({fetch_rd_valid_i, fetch_load_i, fetch_mul_i})
    ) else $error("issue_select: fetch changed a refused instruction");

endmodule

// File: verilog/pipe_track.sv
`timescale 1ns/1ps

module pipe_track
    import issue_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    // Instruction entering E1
    input  logic     issue_i,
    input  reg_idx_t issue_rd_i,
    input  logic     issue_rd_valid_i,
    input  logic     issue_load_i,
    input  logic     issue_mul_i,

    // Execution unit results
    input  word_t    alu_result_e1_i,
    input  logic     mem_valid_i,
    input  word_t    mem_result_i,
    input  word_t    mul_result_e2_i,

    // E1 status
    output logic     e1_busy_o,
    output logic     e1_alu_o,
    output reg_idx_t e1_rd_o,

    // E2 status
    output logic     e2_valid_o,
    output reg_idx_t e2_rd_o,
    output word_t    e2_result_o,

    output logic     stall_o,

    // Writeback
    output logic     wb_valid_o,
    output reg_idx_t wb_rd_o,
    output word_t    wb_result_o
);

    // E1
    logic     e1_valid_q;
    logic     e1_load_q;
    logic     e1_mul_q;
    logic     e1_rd_valid_q;
    reg_idx_t e1_rd_q;

    // E2
    logic     e2_valid_q;
    logic     e2_load_q;
    logic     e2_mul_q;
    logic     e2_rd_valid_q;
    reg_idx_t e2_rd_q;
    word_t    e2_alu_q;

    // Writeback
    logic     wb_valid_q;
    reg_idx_t wb_rd_q;
    word_t    wb_result_q;

    logic     stall_w;
    word_t    e2_result_w;

    // Load in E2 still waiting on memory
    assign stall_w = e2_valid_q && e2_load_q && !mem_valid_i;

    // Result leaving E2
    always_comb
    begin
        if (e2_load_q)
            e2_result_w = mem_result_i;
        else if (e2_mul_q)
            e2_result_w = mul_result_e2_i;
        else
            e2_result_w = e2_alu_q;
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            e1_valid_q    <= 1'b0;
            e1_load_q     <= 1'b0;
            e1_mul_q      <= 1'b0;
            e1_rd_valid_q <= 1'b0;
            e2_valid_q    <= 1'b0;
            e2_load_q     <= 1'b0;
            e2_mul_q      <= 1'b0;
            e2_rd_valid_q <= 1'b0;
            wb_valid_q    <= 1'b0;
        end
        else if (!stall_w)
        begin
            e1_valid_q    <= issue_i;
            e1_load_q     <= issue_i && issue_load_i;
            e1_mul_q      <= issue_i && issue_mul_i;
            e1_rd_valid_q <= issue_i && issue_rd_valid_i;
            e2_valid_q    <= e1_valid_q;
            e2_load_q     <= e1_load_q;
            e2_mul_q      <= e1_mul_q;
            e2_rd_valid_q <= e1_rd_valid_q;
            // Only register writers commit
            wb_valid_q    <= e2_valid_q && e2_rd_valid_q;
        end
        else
        begin
            // E1 and E2 frozen with a bubble into writeback
            wb_valid_q    <= 1'b0;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!stall_w)
        begin
            e1_rd_q     <= issue_rd_i;
            e2_rd_q     <= e1_rd_q;
            e2_alu_q    <= alu_result_e1_i;
            wb_rd_q     <= e2_rd_q;
            wb_result_q <= e2_result_w;
        end
    end

    // Producers the scoreboard must wait for
    assign e1_busy_o = e1_valid_q && (e1_load_q || e1_mul_q);

    // ALU result usable for bypass straight from E1
    assign e1_alu_o  = e1_valid_q && e1_rd_valid_q && !e1_load_q && !e1_mul_q;
    assign e1_rd_o   = e1_rd_q;

    assign e2_valid_o  = e2_valid_q && e2_rd_valid_q;
    assign e2_rd_o     = e2_rd_q;
    assign e2_result_o = e2_result_w;

    assign stall_o = stall_w;

    assign wb_valid_o  = wb_valid_q;
    assign wb_rd_o     = wb_rd_q;
    assign wb_result_o = wb_result_q;

    // Nothing enters E1 while a load waits in E2
    a_no_issue_in_stall : assert property (
        @(posedge clk_i) disable iff (rst_i)
        issue_i |-> !stall_w
    ) else $error("pipe_track: issue while the pipe is stalled");

    // Destination carried from issue must be known by writeback
    a_wb_rd_known : assert property (
        @(posedge clk_i) disable iff (rst_i)
        wb_valid_q |-> !$isunknown(wb_rd_q)
    ) else $error("pipe_track: writeback destination unknown");

endmodule

// File: verilog/regfile_bypass.sv
`timescale 1ns/1ps

module regfile_bypass
    import issue_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    // Read indices from the issuing instruction
    input  reg_idx_t ra_idx_i,
    input  reg_idx_t rb_idx_i,

    // E1 ALU result
    input  logic     e1_alu_i,
    input  reg_idx_t e1_rd_i,
    input  word_t    alu_result_e1_i,

    // E2 result
    input  logic     e2_valid_i,
    input  reg_idx_t e2_rd_i,
    input  word_t    e2_result_i,

    // Writeback, also the write port
    input  logic     wb_valid_i,
    input  reg_idx_t wb_rd_i,
    input  word_t    wb_result_i,

    output word_t    ra_operand_o,
    output word_t    rb_operand_o
);

    word_t regs_q [NUM_REGS];
    word_t ra_value_w;
    word_t rb_value_w;

    // Single write port, x0 never written
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs_q[i] <= '0;
        end
        else if (wb_valid_i && (wb_rd_i != REG_ZERO))
        begin
            regs_q[wb_rd_i] <= wb_result_i;
        end
    end

    // Later checks win, so the youngest producer overrides older ones
    function automatic word_t pick_operand(input reg_idx_t idx);
        word_t value;
        value = regs_q[idx];
        if (wb_valid_i && (wb_rd_i == idx))
            value = wb_result_i;
        if (e2_valid_i && (e2_rd_i == idx))
            value = e2_result_i;
        if (e1_alu_i && (e1_rd_i == idx))
            value = alu_result_e1_i;
        // x0 is hardwired
        if (idx == REG_ZERO)
            value = '0;
        return value;
    endfunction

    always_comb
    begin
        ra_value_w = pick_operand(ra_idx_i);
        rb_value_w = pick_operand(rb_idx_i);
    end

    assign ra_operand_o = ra_value_w;
    assign rb_operand_o = rb_value_w;

endmodule

// File: verilog/issue_top.sv
`timescale 1ns/1ps

module issue_top
    import issue_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,

    // Fetch
    input  logic     fetch_valid_i,
    input  word_t    fetch_instr_i,
    input  logic     fetch_rd_valid_i,
    input  logic     fetch_load_i,
    input  logic     fetch_mul_i,

    // Execution unit results
    input  word_t    alu_result_e1_i,
    input  logic     mem_valid_i,
    input  word_t    mem_result_i,
    input  word_t    mul_result_e2_i,

    output logic     fetch_accept_o,
    output logic     opcode_valid_o,
    output word_t    opcode_ra_operand_o,
    output word_t    opcode_rb_operand_o,
    output logic     exec_hold_o,

    // Commit
    output logic     commit_valid_o,
    output reg_idx_t commit_rd_o,
    output word_t    commit_value_o
);

    logic     issue_w;
    reg_idx_t ra_idx_w;
    reg_idx_t rb_idx_w;
    reg_idx_t rd_idx_w;
    logic     e1_busy_w;
    logic     e1_alu_w;
    reg_idx_t e1_rd_w;
    logic     e2_valid_w;
    reg_idx_t e2_rd_w;
    word_t    e2_result_w;
    logic     stall_w;
    logic     wb_valid_w;
    reg_idx_t wb_rd_w;
    word_t    wb_result_w;

    issue_select issue_select_inst
    (
        .clk_i,
        .rst_i,
        .fetch_valid_i,
        .fetch_instr_i,
        .fetch_rd_valid_i,
        .fetch_load_i,
        .fetch_mul_i,
        .e1_busy_i      (e1_busy_w),
        .e1_rd_i        (e1_rd_w),
        .stall_i        (stall_w),
        .issue_o        (issue_w),
        .fetch_accept_o,
        .opcode_valid_o,
        .ra_idx_o       (ra_idx_w),
        .rb_idx_o       (rb_idx_w),
        .rd_idx_o       (rd_idx_w)
    );

    pipe_track pipe_track_inst
    (
        .clk_i,
        .rst_i,
        .issue_i          (issue_w),
        .issue_rd_i       (rd_idx_w),
        .issue_rd_valid_i (fetch_rd_valid_i),
        .issue_load_i     (fetch_load_i),
        .issue_mul_i      (fetch_mul_i),
        .alu_result_e1_i,
        .mem_valid_i,
        .mem_result_i,
        .mul_result_e2_i,
        .e1_busy_o        (e1_busy_w),
        .e1_alu_o         (e1_alu_w),
        .e1_rd_o          (e1_rd_w),
        .e2_valid_o       (e2_valid_w),
        .e2_rd_o          (e2_rd_w),
        .e2_result_o      (e2_result_w),
        .stall_o          (stall_w),
        .wb_valid_o       (wb_valid_w),
        .wb_rd_o          (wb_rd_w),
        .wb_result_o      (wb_result_w)
    );

    regfile_bypass regfile_bypass_inst
    (
        .clk_i,
        .rst_i,
        .ra_idx_i     (ra_idx_w),
        .rb_idx_i     (rb_idx_w),
        .e1_alu_i     (e1_alu_w),
        .e1_rd_i      (e1_rd_w),
        .alu_result_e1_i,
        .e2_valid_i   (e2_valid_w),
        .e2_rd_i      (e2_rd_w),
        .e2_result_i  (e2_result_w),
        .wb_valid_i   (wb_valid_w),
        .wb_rd_i      (wb_rd_w),
        .wb_result_i  (wb_result_w),
        .ra_operand_o (opcode_ra_operand_o),
        .rb_operand_o (opcode_rb_operand_o)
    );

    // Execution units hold while a load waits on memory
    assign exec_hold_o = stall_w;

    assign commit_valid_o = wb_valid_w;
    assign commit_rd_o    = wb_rd_w;
    assign commit_value_o = wb_result_w;

endmodule

// File: sim/issue_tb.sv
`timescale 1ns/1ps

module issue_tb
    import issue_pkg::*;
();

    localparam int KIND_ALU  = 0;
    localparam int KIND_LOAD = 1;
    localparam int KIND_MUL  = 2;

    logic     clk_i;
    logic     rst_i;
    logic     fetch_valid_i;
    word_t    fetch_instr_i;
    logic     fetch_rd_valid_i;
    logic     fetch_load_i;
    logic     fetch_mul_i;
    word_t    alu_result_e1_i;
    logic     mem_valid_i;
    word_t    mem_result_i;
    word_t    mul_result_e2_i;

    logic     fetch_accept_o;
    logic     opcode_valid_o;
    word_t    opcode_ra_operand_o;
    word_t    opcode_rb_operand_o;
    logic     exec_hold_o;
    logic     commit_valid_o;
    reg_idx_t commit_rd_o;
    word_t    commit_value_o;

    // One entry per instruction in the case file
    int       c_kind[$];
    logic     c_rd_valid[$];
    reg_idx_t c_rd[$];
    reg_idx_t c_ra[$];
    reg_idx_t c_rb[$];
    word_t    c_data[$];
    int       c_delay[$];
    word_t    c_result[$];
    int       num_cases;
    int       delay_sum;

    // Register state in program order, and retire order
    word_t    model_regs[NUM_REGS];
    int       commit_q[$];

    // Case held in each stage, -1 for a bubble
    int       e1_case;
    int       e2_case;
    int       mem_wait;

    int       cycle_count;
    int       cycle_limit;

    issue_top issue_top_inst (.*);

    always #2 clk_i = ~clk_i;

    task automatic stop_with_failure(input string reason);
        $display("Test failed");
        $fatal(1, "%s", reason);
    endtask

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit))
            stop_with_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            stop_with_failure("Operand value mismatch");
        end
    endtask

    task automatic compare_commit(input string name, input reg_idx_t exp_rd, input word_t exp_val,
                                  input reg_idx_t act_rd, input word_t act_val);
        if ((act_rd !== exp_rd) || (act_val !== exp_val))
        begin
            $display("** Error: %s expected rd %0d value %h actual rd %0d value %h",
                     name, exp_rd, exp_val, act_rd, act_val);
            stop_with_failure("Commit mismatch");
        end
    endtask

    task automatic compare_level(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            stop_with_failure("Control level mismatch");
        end
    endtask

    function automatic word_t build_instr(input int kind, input reg_idx_t rd,
                                          input reg_idx_t ra, input reg_idx_t rb);
        word_t instr;
        instr = '0;
        instr[6:0] = (kind == KIND_LOAD) ? 7'h03 : 7'h33;
        // funct7 of 1 marks a multiply
        instr[25] = (kind == KIND_MUL);
        instr[RD_LSB +: REG_IDX_W]  = rd;
        instr[RS1_LSB +: REG_IDX_W] = ra;
        instr[RS2_LSB +: REG_IDX_W] = rb;
        return instr;
    endfunction

    task automatic load_cases();
        int    fd;
        int    got;
        string line;
        int    f_kind;
        int    f_rdv;
        int    f_rd;
        int    f_ra;
        int    f_rb;
        int    f_delay;
        word_t f_data;
        fd = $fopen("sim/issue_cases.txt", "r");
        if (fd == 0)
            stop_with_failure("Cannot open the case file sim/issue_cases.txt");
        else
        begin
            while (!$feof(fd))
            begin
                got = $fgets(line, fd);
                // Skip blank lines and lines starting with a hash
                if ((got > 1) && (line.getc(0) != 8'h23))
                begin
                    got = $sscanf(line, "%d %d %d %d %d %h %d",
                                  f_kind, f_rdv, f_rd, f_ra, f_rb, f_data, f_delay);
                    if (got == 7)
                    begin
                        c_kind.push_back(f_kind);
                        c_rd_valid.push_back(f_rdv != 0);
                        c_rd.push_back(reg_idx_t'(f_rd));
                        c_ra.push_back(reg_idx_t'(f_ra));
                        c_rb.push_back(reg_idx_t'(f_rb));
                        c_data.push_back(f_data);
                        c_delay.push_back(f_delay);
                        c_result.push_back('0);
                        delay_sum = delay_sum + f_delay;
                    end
                end
            end
            $fclose(fd);
            num_cases = c_kind.size();
        end
    endtask

    initial
    begin
        int    cur;
        int    next_case;
        int    drain;
        int    done_idx;
        logic  stall_exp;
        logic  hazard;
        logic  accept_exp;
        word_t op_a;
        word_t op_b;

        clk_i            = 1'b0;
        rst_i            = 1'b1;
        fetch_valid_i    = 1'b0;
        fetch_instr_i    = '0;
        fetch_rd_valid_i = 1'b0;
        fetch_load_i     = 1'b0;
        fetch_mul_i      = 1'b0;
        alu_result_e1_i  = '0;
        mem_valid_i      = 1'b0;
        mem_result_i     = '0;
        mul_result_e2_i  = '0;
        cycle_count      = 0;
        cycle_limit      = 0;
        num_cases        = 0;
        delay_sum        = 0;
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;

        load_cases();
        cycle_limit = 20 * num_cases + delay_sum;

        cur       = -1;
        next_case = 0;
        drain     = 0;
        e1_case   = -1;
        e2_case   = -1;
        mem_wait  = 0;

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        while (drain < 3)
        begin
            @(posedge clk_i);

            // Load in E2 without its data freezes the pipe
            stall_exp = (e2_case >= 0) && (c_kind[e2_case] == KIND_LOAD) && (mem_wait > 0);
            compare_level("exec_hold_o", stall_exp, exec_hold_o);

            hazard = 1'b0;
            if ((cur >= 0) && (e1_case >= 0))
            begin
                if (c_kind[e1_case] != KIND_ALU)
                    hazard = (c_rd[e1_case] == c_rd[cur]) || (c_rd[e1_case] == c_ra[cur])
                             || (c_rd[e1_case] == c_rb[cur]);
            end
            accept_exp = (cur < 0) || (!stall_exp && !hazard);
            compare_level($sformatf("case %0d fetch_accept_o", cur), accept_exp, fetch_accept_o);
            compare_level("opcode_valid_o", (cur >= 0) && accept_exp, opcode_valid_o);

            if (commit_valid_o === 1'b1)
            begin
                if (commit_q.size() == 0)
                    stop_with_failure("Commit seen with no instruction left to retire");
                else
                begin
                    done_idx = commit_q.pop_front();
                    compare_commit($sformatf("case %0d commit", done_idx), c_rd[done_idx],
                                   c_result[done_idx], commit_rd_o, commit_value_o);
                end
            end

            if ((cur >= 0) && accept_exp)
            begin
                op_a = model_regs[c_ra[cur]];
                op_b = model_regs[c_rb[cur]];
                compare_word($sformatf("case %0d ra operand", cur), op_a, opcode_ra_operand_o);
                compare_word($sformatf("case %0d rb operand", cur), op_b, opcode_rb_operand_o);
                if (c_kind[cur] == KIND_ALU)
                    c_result[cur] = op_a + op_b;
                else if (c_kind[cur] == KIND_MUL)
                    c_result[cur] = op_a * op_b;
                else
                    c_result[cur] = c_data[cur];
                if (c_rd_valid[cur])
                begin
                    commit_q.push_back(cur);
                    if (c_rd[cur] != REG_ZERO)
                        model_regs[c_rd[cur]] = c_result[cur];
                end
            end

            // Execution units, ALU input stays put while held
            if (stall_exp)
            begin
                mem_wait = mem_wait - 1;
                mem_valid_i <= (mem_wait == 0);
            end
            else
            begin
                e2_case = e1_case;
                e1_case = ((cur >= 0) && accept_exp) ? cur : -1;
                if ((e2_case >= 0) && (c_kind[e2_case] == KIND_LOAD))
                begin
                    mem_wait = c_delay[e2_case];
                    mem_valid_i  <= (mem_wait == 0);
                    mem_result_i <= c_data[e2_case];
                end
                else
                    mem_valid_i <= 1'b0;
                if ((e2_case >= 0) && (c_kind[e2_case] == KIND_MUL))
                    mul_result_e2_i <= c_result[e2_case];
                if ((e1_case >= 0) && (c_kind[e1_case] == KIND_ALU))
                    alu_result_e1_i <= c_result[e1_case];
            end

            // Next instruction once the current one is taken
            if (accept_exp)
            begin
                if (next_case < num_cases)
                begin
                    cur = next_case;
                    next_case = next_case + 1;
                    fetch_valid_i    <= 1'b1;
                    fetch_instr_i    <= build_instr(c_kind[cur], c_rd[cur], c_ra[cur], c_rb[cur]);
                    fetch_rd_valid_i <= c_rd_valid[cur];
                    fetch_load_i     <= (c_kind[cur] == KIND_LOAD);
                    fetch_mul_i      <= (c_kind[cur] == KIND_MUL);
                end
                else
                begin
                    cur = -1;
                    fetch_valid_i <= 1'b0;
                end
            end

            if ((cur < 0) && (next_case == num_cases) && (e1_case < 0) && (e2_case < 0))
                drain = drain + 1;
        end

        if (commit_q.size() != 0)
            stop_with_failure("Expected commits never appeared");
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: compile.f
verilog/issue_pkg.sv
verilog/issue_select.sv
verilog/pipe_track.sv
verilog/regfile_bypass.sv
verilog/issue_top.sv
sim/issue_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module issue_tb -f compile.f \
    && ./obj_dir/Vissue_tb \
    || exit 1

// File: sim/issue_cases.txt
# kind rd_valid rd ra rb load_data mem_delay
# kind 0 is ALU, 1 load, 2 mul; indices decimal; load_data hex; delay in cycles
1 1 1 0 0 00000011 0
1 1 2 0 0 00000022 0
0 1 3 1 2 00000000 0
0 1 4 3 3 00000000 0
0 1 5 4 1 00000000 0
2 1 6 5 4 00000000 0
0 1 7 6 0 00000000 0
0 1 0 7 7 00000000 0
0 1 8 0 7 00000000 0
1 1 9 8 0 deadbeef 3
0 1 10 9 8 00000000 0
0 0 11 10 10 00000000 0
0 1 12 11 10 00000000 0
1 1 13 0 0 0000abcd 1
2 1 14 13 12 00000000 0
0 1 15 14 13 00000000 0
1 0 16 0 0 12345678 2
0 1 16 15 15 00000000 0
2 1 0 16 16 00000000 0
0 1 17 0 16 00000000 0
1 1 18 17 17 55aa55aa 4
2 1 19 18 18 00000000 0
0 1 20 19 18 00000000 0
0 1 21 20 0 00000000 0
